// ==== verification/decode_patterns.mem ====
// instr pc illegal itype alu_sel muldiv_sel in0_sel in1_sel shamt_sel rd_sel
// one instruction per line, all values hex
00c58533 00001000 0 1 0 0 0 0 0 0 // add
40c58533 00001004 0 1 1 0 0 0 0 0 // sub
00c59533 00001008 0 1 4 0 0 0 0 0 // sll
00c5a533 0000100c 0 1 2 0 0 0 0 0 // slt
00c5b533 00001010 0 1 3 0 0 0 0 0 // sltu
00c5c533 00001014 0 1 7 0 0 0 0 0 // xor
00c5d533 00001018 0 1 5 0 0 0 0 0 // srl
40c5d533 0000101c 0 1 6 0 0 0 0 0 // sra
00c5e533 00001020 0 1 8 0 0 0 0 0 // or
00c5f533 00001024 0 1 9 0 0 0 0 0 // and
02c58533 00001028 0 2 0 0 0 0 0 1 // mul
02c59533 0000102c 0 2 0 1 0 0 0 1 // mulh
02c5a533 00001030 0 2 0 2 0 0 0 1 // mulhsu
02c5b533 00001034 0 2 0 3 0 0 0 1 // mulhu
02c5c533 00001038 0 2 0 4 0 0 0 1 // div
02c5d533 0000103c 0 2 0 5 0 0 0 1 // divu
02c5e533 00001040 0 2 0 6 0 0 0 1 // rem
02c5f533 00001044 0 2 0 7 0 0 0 1 // remu
fff58513 00001048 0 1 0 0 0 1 1 0 // addi
0055a513 0000104c 0 1 2 0 0 1 1 0 // slti
0055b513 00001050 0 1 3 0 0 1 1 0 // sltiu
0055c513 00001054 0 1 7 0 0 1 1 0 // xori
0055e513 00001058 0 1 8 0 0 1 1 0 // ori
0055f513 0000105c 0 1 9 0 0 1 1 0 // andi
00359513 00001060 0 1 4 0 0 1 1 0 // slli
0035d513 00001064 0 1 5 0 0 1 1 0 // srli
4035d513 00001068 0 1 6 0 0 1 1 0 // srai
008000ef 0000106c 0 3 0 0 1 2 0 0 // jal
000580e7 00001070 0 3 0 0 0 1 0 0 // jalr
12345537 00001074 0 1 0 0 0 0 0 2 // lui
12345517 00001078 0 1 0 0 1 5 0 0 // auipc
00c58463 0000107c 0 4 0 0 1 3 0 0 // beq
00c59463 00001080 0 4 0 0 1 3 0 0 // bne
00c5c463 00001084 0 4 0 0 1 3 0 0 // blt
00c5d463 00001088 0 4 0 0 1 3 0 0 // bge
00c5e463 0000108c 0 4 0 0 1 3 0 0 // bltu
00c5f463 00001090 0 4 0 0 1 3 0 0 // bgeu
00458503 00001094 0 5 0 0 0 1 0 3 // lb
00459503 00001098 0 5 0 0 0 1 0 3 // lh
0045a503 0000109c 0 5 0 0 0 1 0 3 // lw
0045c503 000010a0 0 5 0 0 0 1 0 3 // lbu
0045d503 000010a4 0 5 0 0 0 1 0 3 // lhu
00c58223 000010a8 0 6 0 0 0 4 0 0 // sb
00c59223 000010ac 0 6 0 0 0 4 0 0 // sh
00c5a223 000010b0 0 6 0 0 0 4 0 0 // sw
20c58533 000010b4 1 0 0 0 0 0 0 0 // OP with bad funct7
00000073 000010b8 1 0 0 0 0 0 0 0 // ecall
0ff0000f 000010bc 1 0 0 0 0 0 0 0 // fence

// ==== list.f ====
+incdir+common
common/rv_decode_pkg.sv
decode/instr_decoder.sv
decode/decode_stage.sv
hdl/decode_top.sv
verification/decode_properties.sv
verification/tb_decode.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
LINTFLAGS = --lint-only --timing
TOP       = tb_decode
FILELIST  = list.f
OBJDIR    = obj_dir
LOG       = sim.log
PASS_MSG  = All tests passed!

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

// ==== verification/tb_decode.sv ====
`include "rv_decode_cfg.svh"

module tb_decode;
    import rv_decode_pkg::*;

    localparam int NUM_PAT  = 48;
    // instr, pc, then the eight control columns
    localparam int PAT_COLS = 10;
    localparam int TIMEOUT  = 200;

    logic       clk;
    logic       rst_n;
    logic       in_valid;
    fetch_pkt_t in_pkt;
    logic       fetch_ready;
    logic       out_valid;
    decoded_t   out;
    logic       exec_ready;
    exec_fb_t   fb;

    logic [31:0] pat_mem [0:NUM_PAT*PAT_COLS-1];
    // Expected item for whatever in_pkt holds right now
    decoded_t    cur_exp;
    decoded_t    exp_q [$];
    logic        rand_ready;
    logic [31:0] rng_state;
    int          err_cnt   = 0;
    int          check_cnt = 0;
    int          sent_cnt  = 0;
    int          leave_cnt = 0;

    decode_top dut_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_valid    (in_valid),
        .in_pkt      (in_pkt),
        .fetch_ready (fetch_ready),
        .out_valid   (out_valid),
        .out         (out),
        .exec_ready  (exec_ready),
        .fb          (fb)
    );

    bind decode_stage decode_properties props_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .fetch_ready (fetch_ready),
        .out_valid   (out_valid),
        .exec_ready  (exec_ready),
        .out         (out)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic fetch_pkt_t pkt_of(input int idx);
        fetch_pkt_t p;
        p.instr = pat_mem[idx*PAT_COLS];
        p.pc    = pat_mem[idx*PAT_COLS+1];
        return p;
    endfunction

    // Expected decode straight from the pattern columns
    function automatic decoded_t exp_of(input int idx);
        decoded_t d;
        int       b;
        b = idx * PAT_COLS;
        d.ctrl.illegal    = pat_mem[b+2][0];
        d.ctrl.itype      = itype_e'(pat_mem[b+3][2:0]);
        d.ctrl.alu_sel    = alu_sel_e'(pat_mem[b+4][3:0]);
        d.ctrl.muldiv_sel = muldiv_sel_e'(pat_mem[b+5][2:0]);
        d.ctrl.in0_sel    = in0_sel_e'(pat_mem[b+6][0]);
        d.ctrl.in1_sel    = in1_sel_e'(pat_mem[b+7][2:0]);
        d.ctrl.shamt_sel  = shamt_sel_e'(pat_mem[b+8][0]);
        d.ctrl.rd_sel     = rd_sel_e'(pat_mem[b+9][1:0]);
        d.instr           = pat_mem[b];
        d.pc              = pat_mem[b+1];
        return d;
    endfunction

    // Source register fields of a pattern
    function automatic logic [`RV_REG_ADDR_W-1:0] rs1_of(input int idx);
        return pat_mem[idx*PAT_COLS][`RV_RS1_MSB:`RV_RS1_LSB];
    endfunction

    function automatic logic [`RV_REG_ADDR_W-1:0] rs2_of(input int idx);
        return pat_mem[idx*PAT_COLS][`RV_RS2_MSB:`RV_RS2_LSB];
    endfunction

    task automatic check_ctrl(input dec_ctrl_t got, input dec_ctrl_t exp, input string what);
        check_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("error %0t: %s ctrl got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_pkt(input fetch_pkt_t got, input fetch_pkt_t exp, input string what);
        check_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("error %0t: %s instr/pc got %h/%h expected %h/%h",
                     $time, what, got.instr, got.pc, exp.instr, exp.pc);
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        check_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("error %0t: %s got %b expected %b", $time, what, got, exp);
        end
    endtask

    // Offer one pattern until fetch takes it
    task automatic send(input int idx, output int waits);
        int n;
        n = 0;
        in_pkt   <= pkt_of(idx);
        cur_exp  <= exp_of(idx);
        in_valid <= 1'b1;
        @(posedge clk);
        while (!fetch_ready && n < TIMEOUT) begin
            n++;
            @(posedge clk);
        end
        if (fetch_ready) begin
            sent_cnt++;
        end else begin
            err_cnt++;
            $display("timeout: pattern %0d was never accepted", idx);
        end
        waits = n;
    endtask

    // Scoreboard sampled between edges
    task automatic wait_drain();
        int n;
        n = 0;
        while (exp_q.size() != 0 && n < TIMEOUT) begin
            n++;
            @(negedge clk);
        end
        if (exp_q.size() != 0) begin
            err_cnt++;
            $display("timeout: %0d items never left the stage", exp_q.size());
        end
        @(posedge clk);
    endtask

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Execute side ready, random stalls when enabled
    initial begin
        rng_state  = 32'h2a602e0c;
        exec_ready = 1'b0;
        forever begin
            @(posedge clk);
            rng_state = xorshift32(rng_state);
            if (rand_ready) begin
                exec_ready <= rng_state[7];
            end else begin
                exec_ready <= 1'b1;
            end
        end
    end

    // Output monitor and scoreboard push
    initial begin
        decoded_t   exp_item;
        fetch_pkt_t got_pkt;
        fetch_pkt_t exp_pkt;
        forever begin
            @(posedge clk);
            if (rst_n) begin
                if (out_valid && exec_ready) begin
                    if (exp_q.size() == 0) begin
                        err_cnt++;
                        $display("unexpected item at the output, pc %h", out.pc);
                    end else begin
                        exp_item      = exp_q.pop_front();
                        got_pkt.instr = out.instr;
                        got_pkt.pc    = out.pc;
                        exp_pkt.instr = exp_item.instr;
                        exp_pkt.pc    = exp_item.pc;
                        check_ctrl(out.ctrl, exp_item.ctrl, $sformatf("pc %h", exp_item.pc));
                        check_pkt(got_pkt, exp_pkt, $sformatf("pc %h", exp_item.pc));
                        leave_cnt++;
                    end
                end
                // Discarded when a command is active
                if (in_valid && fetch_ready && fb.cmd == CMD_NONE) begin
                    exp_q.push_back(cur_exp);
                end
            end
        end
    end

    initial begin
        int        w;
        pipe_cmd_e cmds [3];
        cmds       = '{CMD_KILL, CMD_FLUSH, CMD_BRANCH};
        rst_n      = 1'b0;
        in_valid   = 1'b0;
        in_pkt     = '0;
        fb         = '{cmd: CMD_NONE, rd_write: 1'b0, rd_waddr: '0};
        cur_exp    = '0;
        rand_ready = 1'b0;
        $readmemh("verification/decode_patterns.mem", pat_mem);
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;

        // Empty stage before any input
        @(posedge clk);
        check_bit(out_valid, 1'b0, "out_valid after reset");
        check_bit(fetch_ready, 1'b0, "fetch_ready with no input");

        // Whole decode table at full rate
        for (int i = 0; i < NUM_PAT; i++) begin
            send(i, w);
        end

        // add a0,a1,a2 behind a pending write of a1, then a2
        fb       <= '{cmd: CMD_NONE, rd_write: 1'b1, rd_waddr: rs1_of(0)};
        in_pkt   <= pkt_of(0);
        cur_exp  <= exp_of(0);
        in_valid <= 1'b1;
        repeat (4) begin
            @(posedge clk);
            check_bit(fetch_ready, 1'b0, "fetch_ready under rs1 hazard");
        end
        fb.rd_waddr <= rs2_of(0);
        repeat (4) begin
            @(posedge clk);
            check_bit(fetch_ready, 1'b0, "fetch_ready under rs2 hazard");
        end
        fb.rd_write <= 1'b0;
        send(0, w);
        check_bit(w == 0, 1'b1, "accept once rd_write drops");

        // Match on an unused source field, jalr then lui
        fb <= '{cmd: CMD_NONE, rd_write: 1'b1, rd_waddr: rs2_of(28)};
        send(28, w);
        check_bit(w == 0, 1'b1, "no stall on unused rs2");
        fb <= '{cmd: CMD_NONE, rd_write: 1'b1, rd_waddr: rs1_of(29)};
        send(29, w);
        check_bit(w == 0, 1'b1, "no stall on unused rs1");
        fb       <= '{cmd: CMD_NONE, rd_write: 1'b0, rd_waddr: '0};
        in_valid <= 1'b0;

        // Random back-pressure, reverse order
        rand_ready <= 1'b1;
        for (int i = NUM_PAT - 1; i >= 0; i--) begin
            send(i, w);
        end
        in_valid <= 1'b0;
        wait_drain();
        rand_ready <= 1'b0;
        repeat (2) @(posedge clk);

        // Held item leaves, offered one is dropped
        for (int c = 0; c < 3; c++) begin
            send(32 + c, w);
            in_pkt  <= pkt_of(11 + c);
            cur_exp <= exp_of(11 + c);
            fb.cmd  <= cmds[c];
            @(posedge clk);
            check_bit(fetch_ready, 1'b1, "fetch_ready during command");
            in_valid <= 1'b0;
            fb.cmd   <= CMD_NONE;
            @(posedge clk);
            check_bit(out_valid, 1'b0, "out_valid after command");
        end

        wait_drain();
        if (leave_cnt != sent_cnt) begin
            err_cnt++;
            $display("item count mismatch: %0d accepted, %0d left", sent_cnt, leave_cnt);
        end
        $display("checks %0d, errors %0d, items %0d", check_cnt, err_cnt, leave_cnt);
        if (err_cnt == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// ==== verification/decode_properties.sv ====
module decode_properties (
    input logic                    clk,
    input logic                    rst_n,
    input logic                    fetch_ready,
    input logic                    out_valid,
    input logic                    exec_ready,
    input rv_decode_pkg::decoded_t out
);

    // Stalled item must not change
    a_out_hold: assert property (
        @(posedge clk) disable iff (!rst_n)
        out_valid && !exec_ready |=> $stable(out)
    ) else $error("out changed while execute stalled");

    // Occupied slot blocks fetch
    a_no_ready_when_full: assert property (
        @(posedge clk) disable iff (!rst_n)
        out_valid && !exec_ready |-> !fetch_ready
    ) else $error("fetch_ready high with the output slot occupied");

    // Synchronous reset empties the stage
    a_reset_empty: assert property (
        @(posedge clk)
        !rst_n |=> !out_valid
    ) else $error("out_valid high in the cycle after reset");

endmodule

// ==== hdl/decode_top.sv ====
module decode_top (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      in_valid,
    input  rv_decode_pkg::fetch_pkt_t in_pkt,
    output logic                      fetch_ready,
    output logic                      out_valid,
    output rv_decode_pkg::decoded_t   out,
    input  logic                      exec_ready,
    input  rv_decode_pkg::exec_fb_t   fb
);
    import rv_decode_pkg::*;

    // Decoder results toward the stage register
    dec_ctrl_t ctrl;
    logic      rs1_used;
    logic      rs2_used;

    instr_decoder decoder_i (
        .instr    (in_pkt.instr),
        .ctrl     (ctrl),
        .rs1_used (rs1_used),
        .rs2_used (rs2_used)
    );

    decode_stage stage_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_valid    (in_valid),
        .in_pkt      (in_pkt),
        .ctrl        (ctrl),
        .rs1_used    (rs1_used),
        .rs2_used    (rs2_used),
        .fetch_ready (fetch_ready),
        .out_valid   (out_valid),
        .out         (out),
        .exec_ready  (exec_ready),
        .fb          (fb)
    );

endmodule

// ==== decode/decode_stage.sv ====
`include "rv_decode_cfg.svh"

module decode_stage (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      in_valid,
    input  rv_decode_pkg::fetch_pkt_t in_pkt,
    input  rv_decode_pkg::dec_ctrl_t  ctrl,
    input  logic                      rs1_used,
    input  logic                      rs2_used,
    output logic                      fetch_ready,
    output logic                      out_valid,
    output rv_decode_pkg::decoded_t   out,
    input  logic                      exec_ready,
    input  rv_decode_pkg::exec_fb_t   fb
);
    import rv_decode_pkg::*;

    logic [`RV_REG_ADDR_W-1:0] rs1;
    logic [`RV_REG_ADDR_W-1:0] rs2;
    logic rs1_hazard;
    logic rs2_hazard;
    logic hazard;
    logic slot_free;
    logic cmd_active;
    logic accept;
    logic out_valid_nxt;

    // Source fields straight from the fetched word
    assign rs1 = in_pkt.instr[`RV_RS1_MSB:`RV_RS1_LSB];
    assign rs2 = in_pkt.instr[`RV_RS2_MSB:`RV_RS2_LSB];

    // Pending writeback in execute, x0 included
    assign rs1_hazard = rs1_used && fb.rd_write && (rs1 == fb.rd_waddr);
    assign rs2_hazard = rs2_used && fb.rd_write && (rs2 == fb.rd_waddr);
    assign hazard     = rs1_hazard || rs2_hazard;

    // Output register empty or draining this cycle
    assign slot_free  = !out_valid || exec_ready;
    assign cmd_active = fb.cmd != CMD_NONE;
    assign accept     = slot_free && !cmd_active && in_valid && !hazard;

    always_comb begin
        // Back-pressure holds everything
        out_valid_nxt = out_valid;
        fetch_ready   = 1'b0;
        if (slot_free) begin
            if (cmd_active) begin
                // Drop held item and whatever fetch offers
                out_valid_nxt = 1'b0;
                fetch_ready   = 1'b1;
            end else if (accept) begin
                out_valid_nxt = 1'b1;
                fetch_ready   = 1'b1;
            end else begin
                // Bubble toward execute
                out_valid_nxt = 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= out_valid_nxt;
        end
    end

    // Payload only loads on accept
    always_ff @(posedge clk) begin
        if (accept) begin
            out.ctrl  <= ctrl;
            out.instr <= in_pkt.instr;
            out.pc    <= in_pkt.pc;
        end
    end

endmodule

// ==== decode/instr_decoder.sv ====
`include "rv_decode_cfg.svh"

module instr_decoder (
    input  logic [`RV_XLEN-1:0]      instr,
    output rv_decode_pkg::dec_ctrl_t ctrl,
    output logic                     rs1_used,
    output logic                     rs2_used
);
    import rv_decode_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    // Opcode level matches
    logic is_op, is_op_imm, is_lui, is_auipc, is_jal, is_jalr;
    logic is_branch, is_load, is_store;

    // Fully checked groups
    logic f7_zero, f7_alt, f7_md, shift_f3;
    logic grp_alu, grp_alui, grp_muldiv, grp_jalr, grp_branch, grp_load, grp_store;

    alu_sel_e alu_f3;

    assign opcode = instr[`RV_OPC_MSB:`RV_OPC_LSB];
    assign funct3 = instr[`RV_F3_MSB:`RV_F3_LSB];
    assign funct7 = instr[`RV_F7_MSB:`RV_F7_LSB];

    assign is_op     = opcode == OPC_OP;
    assign is_op_imm = opcode == OPC_OP_IMM;
    assign is_lui    = opcode == OPC_LUI;
    assign is_auipc  = opcode == OPC_AUIPC;
    assign is_jal    = opcode == OPC_JAL;
    assign is_jalr   = opcode == OPC_JALR;
    assign is_branch = opcode == OPC_BRANCH;
    assign is_load   = opcode == OPC_LOAD;
    assign is_store  = opcode == OPC_STORE;

    assign f7_zero  = funct7 == 7'b0000000;
    assign f7_alt   = funct7 == 7'b0100000;
    assign f7_md    = funct7 == 7'b0000001;
    assign shift_f3 = (funct3 == 3'b001) || (funct3 == 3'b101);

    // Alternate funct7 only valid for SUB and SRA
    assign grp_alu = is_op && (f7_zero || (f7_alt && (funct3 == 3'b000 || funct3 == 3'b101)));
    assign grp_muldiv = is_op && f7_md;
    // Shift immediates carry funct7 in imm[11:5]
    assign grp_alui = is_op_imm && (!shift_f3 || f7_zero || (f7_alt && funct3 == 3'b101));
    assign grp_jalr = is_jalr && (funct3 == 3'b000);
    // funct3 010 and 011 unused by branches
    assign grp_branch = is_branch && (funct3[2:1] != 2'b01);
    // LB LH LW LBU LHU
    assign grp_load = is_load && (funct3 != 3'b011) && (funct3[2:1] != 2'b11);
    // SB SH SW
    assign grp_store = is_store && !funct3[2] && (funct3[1:0] != 2'b11);

    // ALU op from funct3, shared by register and immediate forms
    always_comb begin
        case (funct3)
            3'b000:  alu_f3 = (is_op && funct7[5]) ? ALU_SUB : ALU_ADD;
            3'b001:  alu_f3 = ALU_SLL;
            3'b010:  alu_f3 = ALU_SLT;
            3'b011:  alu_f3 = ALU_SLTU;
            3'b100:  alu_f3 = ALU_XOR;
            3'b101:  alu_f3 = funct7[5] ? ALU_SRA : ALU_SRL;
            3'b110:  alu_f3 = ALU_OR;
            default: alu_f3 = ALU_AND;
        endcase
    end

    always_comb begin
        // Defaults
        ctrl.illegal    = 1'b0;
        ctrl.itype      = ITYPE_NOP;
        ctrl.alu_sel    = ALU_ADD;
        ctrl.muldiv_sel = MD_MUL;
        ctrl.in0_sel    = IN0_RS1;
        ctrl.in1_sel    = IN1_RS2;
        ctrl.shamt_sel  = SHAMT_RS2;
        ctrl.rd_sel     = RD_ALU;
        case (1'b1)
            grp_alu: begin
                ctrl.itype   = ITYPE_ALU;
                ctrl.alu_sel = alu_f3;
            end
            grp_alui: begin
                ctrl.itype     = ITYPE_ALU;
                ctrl.alu_sel   = alu_f3;
                ctrl.in1_sel   = IN1_SIMM12;
                ctrl.shamt_sel = SHAMT_IMM;
            end
            grp_muldiv: begin
                ctrl.itype      = ITYPE_MULDIV;
                ctrl.muldiv_sel = muldiv_sel_e'(funct3);
                ctrl.rd_sel     = RD_MULDIV;
            end
            is_jal: begin
                ctrl.itype   = ITYPE_JUMP;
                ctrl.in0_sel = IN0_PC;
                ctrl.in1_sel = IN1_JAL_OFFSET;
            end
            grp_jalr: begin
                ctrl.itype   = ITYPE_JUMP;
                ctrl.in1_sel = IN1_SIMM12;
            end
            is_lui: begin
                ctrl.itype  = ITYPE_ALU;
                ctrl.rd_sel = RD_LUI;
            end
            is_auipc: begin
                ctrl.itype   = ITYPE_ALU;
                ctrl.in0_sel = IN0_PC;
                ctrl.in1_sel = IN1_CONST4;
            end
            grp_branch: begin
                ctrl.itype   = ITYPE_BRANCH;
                ctrl.in0_sel = IN0_PC;
                ctrl.in1_sel = IN1_BRANCH_OFFSET;
            end
            grp_load: begin
                ctrl.itype   = ITYPE_LOAD;
                ctrl.in1_sel = IN1_SIMM12;
                ctrl.rd_sel  = RD_MEMORY;
            end
            grp_store: begin
                ctrl.itype   = ITYPE_STORE;
                ctrl.in1_sel = IN1_STORE_IMM;
            end
            // Anything else stays a NOP
            default: ctrl.illegal = 1'b1;
        endcase
    end

    // Register use follows the opcode only
    assign rs1_used = is_op || is_op_imm || is_jalr || is_branch || is_load;
    assign rs2_used = is_op || is_branch || is_store;

endmodule

// ==== common/rv_decode_pkg.sv ====
`include "rv_decode_cfg.svh"

package rv_decode_pkg;

    // RV32 major opcodes handled by this stage
    typedef enum logic [6:0] {
        OPC_LOAD   = 7'b0000011,
        OPC_OP_IMM = 7'b0010011,
        OPC_AUIPC  = 7'b0010111,
        OPC_STORE  = 7'b0100011,
        OPC_OP     = 7'b0110011,
        OPC_LUI    = 7'b0110111,
        OPC_BRANCH = 7'b1100011,
        OPC_JALR   = 7'b1100111,
        OPC_JAL    = 7'b1101111
    } opcode_e;

    // Command from execute
    typedef enum logic [1:0] {
        CMD_NONE, CMD_KILL, CMD_FLUSH, CMD_BRANCH
    } pipe_cmd_e;

    // Instruction class seen by execute
    typedef enum logic [2:0] {
        ITYPE_NOP, ITYPE_ALU, ITYPE_MULDIV, ITYPE_JUMP,
        ITYPE_BRANCH, ITYPE_LOAD, ITYPE_STORE
    } itype_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU, ALU_SLL,
        ALU_SRL, ALU_SRA, ALU_XOR, ALU_OR, ALU_AND
    } alu_sel_e;

    // Same order as funct3 of the M extension
    typedef enum logic [2:0] {
        MD_MUL, MD_MULH, MD_MULHSU, MD_MULHU,
        MD_DIV, MD_DIVU, MD_REM, MD_REMU
    } muldiv_sel_e;

    typedef enum logic {IN0_RS1, IN0_PC} in0_sel_e;

    typedef enum logic [2:0] {
        IN1_RS2, IN1_SIMM12, IN1_JAL_OFFSET,
        IN1_BRANCH_OFFSET, IN1_STORE_IMM, IN1_CONST4
    } in1_sel_e;

    typedef enum logic {SHAMT_RS2, SHAMT_IMM} shamt_sel_e;

    // Writeback source
    typedef enum logic [1:0] {RD_ALU, RD_MULDIV, RD_LUI, RD_MEMORY} rd_sel_e;

    typedef struct packed {
        logic [`RV_XLEN-1:0] instr;
        logic [`RV_XLEN-1:0] pc;
    } fetch_pkt_t;

    typedef struct packed {
        pipe_cmd_e                 cmd;
        logic                      rd_write;
        logic [`RV_REG_ADDR_W-1:0] rd_waddr;
    } exec_fb_t;

    typedef struct packed {
        logic        illegal;
        itype_e      itype;
        alu_sel_e    alu_sel;
        muldiv_sel_e muldiv_sel;
        in0_sel_e    in0_sel;
        in1_sel_e    in1_sel;
        shamt_sel_e  shamt_sel;
        rd_sel_e     rd_sel;
    } dec_ctrl_t;

    typedef struct packed {
        dec_ctrl_t           ctrl;
        logic [`RV_XLEN-1:0] instr;
        logic [`RV_XLEN-1:0] pc;
    } decoded_t;

endpackage

// ==== common/rv_decode_cfg.svh ====
`ifndef RV_DECODE_CFG_SVH
`define RV_DECODE_CFG_SVH

// Instruction word and PC width
`define RV_XLEN         32

// Register file address width
`define RV_REG_ADDR_W   5

// Major opcode field
`define RV_OPC_MSB      6
`define RV_OPC_LSB      0

// funct3 and funct7 fields
`define RV_F3_MSB       14
`define RV_F3_LSB       12
`define RV_F7_MSB       31
`define RV_F7_LSB       25

// Source register fields
`define RV_RS1_MSB      19
`define RV_RS1_LSB      15
`define RV_RS2_MSB      24
`define RV_RS2_LSB      20

`endif
